// File: run_sim.sh
#!/usr/bin/env bash
# build the single-cycle core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f single_cycle.f --top-module single_cycle_tb

out=$(./obj_dir/Vsingle_cycle_tb 2>&1) || true
echo "$out"

if grep -qx "Test passed" <<< "$out"; then
  exit 0
else
  exit 1
fi

// File: single_cycle.f
+incdir+verification
source/cpu_types_pkg.sv
source/cpu_mem_pkg.sv
source/control_unit.sv
source/request_unit.sv
source/register_file.sv
source/alu.sv
source/datapath.sv
source/unified_memory.sv
source/single_cycle.sv
verification/single_cycle_tb.sv

// File: source/alu.sv
//###########################################################################
// ALU: eight operations with a zero flag
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  cpu_types_pkg::aluop_t aluop,
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  output cpu_types_pkg::word_t  outport,
  output logic                  zero
);

  logic slt_s;
  logic slt_u;

  assign slt_s = $signed(port_a) < $signed(port_b);
  assign slt_u = port_a < port_b;

  always_comb begin
    case (aluop)
      cpu_types_pkg::ALU_ADD:  outport = port_a + port_b;
      cpu_types_pkg::ALU_SUB:  outport = port_a - port_b;
      cpu_types_pkg::ALU_AND:  outport = port_a & port_b;
      cpu_types_pkg::ALU_OR:   outport = port_a | port_b;
      cpu_types_pkg::ALU_XOR:  outport = port_a ^ port_b;
      cpu_types_pkg::ALU_NOR:  outport = ~(port_a | port_b);
      // set-less-than results are a single bit in the lsb
      cpu_types_pkg::ALU_SLT:  outport = {31'b0, slt_s};
      cpu_types_pkg::ALU_SLTU: outport = {31'b0, slt_u};
      default:                 outport = '0;
    endcase
  end

  assign zero = (outport == '0);

endmodule

`default_nettype wire

// File: source/control_unit.sv
//###########################################################################
// control unit: instruction word to control word decode
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  cpu_types_pkg::word_t instr,
  output cpu_types_pkg::ctrl_t ctrl
);

  cpu_types_pkg::r_t rtype;

  assign rtype = instr;

  always_comb begin
    // no-op unless the opcode says otherwise
    ctrl         = '0;
    ctrl.aluop   = cpu_types_pkg::ALU_ADD;
    ctrl.imm_sel = cpu_types_pkg::IMM_SIGN;
    ctrl.reg_dst = cpu_types_pkg::DST_RT;

    case (rtype.opcode)
      cpu_types_pkg::RTYPE: begin
        ctrl.reg_dst = cpu_types_pkg::DST_RD;
        ctrl.reg_wr  = 1'b1;
        case (rtype.funct)
          cpu_types_pkg::ADDU: ctrl.aluop = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: ctrl.aluop = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  ctrl.aluop = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   ctrl.aluop = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::XOR:  ctrl.aluop = cpu_types_pkg::ALU_XOR;
          cpu_types_pkg::NOR:  ctrl.aluop = cpu_types_pkg::ALU_NOR;
          cpu_types_pkg::SLT:  ctrl.aluop = cpu_types_pkg::ALU_SLT;
          cpu_types_pkg::SLTU: ctrl.aluop = cpu_types_pkg::ALU_SLTU;
          cpu_types_pkg::JR: begin
            ctrl.jreg   = 1'b1;
            ctrl.reg_wr = 1'b0;
          end
          default: ctrl.reg_wr = 1'b0;
        endcase
      end
      cpu_types_pkg::J: ctrl.jump = 1'b1;
      cpu_types_pkg::JAL: begin
        ctrl.jal     = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.reg_dst = cpu_types_pkg::DST_RA;
      end
      // branches compare by subtraction
      cpu_types_pkg::BEQ: begin
        ctrl.beq   = 1'b1;
        ctrl.aluop = cpu_types_pkg::ALU_SUB;
      end
      cpu_types_pkg::BNE: begin
        ctrl.bne   = 1'b1;
        ctrl.aluop = cpu_types_pkg::ALU_SUB;
      end
      cpu_types_pkg::ADDIU: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
      end
      cpu_types_pkg::SLTI: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.aluop   = cpu_types_pkg::ALU_SLT;
      end
      cpu_types_pkg::ANDI: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.imm_sel = cpu_types_pkg::IMM_ZERO;
        ctrl.aluop   = cpu_types_pkg::ALU_AND;
      end
      cpu_types_pkg::ORI: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.imm_sel = cpu_types_pkg::IMM_ZERO;
        ctrl.aluop   = cpu_types_pkg::ALU_OR;
      end
      cpu_types_pkg::XORI: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.imm_sel = cpu_types_pkg::IMM_ZERO;
        ctrl.aluop   = cpu_types_pkg::ALU_XOR;
      end
      // upper half placed by the immediate path, A operand forced to zero
      cpu_types_pkg::LUI: begin
        ctrl.alu_src = 1'b1;
        ctrl.reg_wr  = 1'b1;
        ctrl.imm_sel = cpu_types_pkg::IMM_LUI;
        ctrl.aluop   = cpu_types_pkg::ALU_OR;
      end
      cpu_types_pkg::LW: begin
        ctrl.alu_src    = 1'b1;
        ctrl.reg_wr     = 1'b1;
        ctrl.mem_rd     = 1'b1;
        ctrl.mem_to_reg = 1'b1;
      end
      cpu_types_pkg::SW: begin
        ctrl.alu_src = 1'b1;
        ctrl.mem_wr  = 1'b1;
      end
      cpu_types_pkg::HALT: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/cpu_mem_pkg.sv
//###########################################################################
// memory side: request and response bundles, load port, array sizing
//###########################################################################
`default_nettype none

package cpu_mem_pkg;

  localparam int MEM_WORDS   = 256;
  localparam int MEM_AW      = 8;
  localparam int MEM_LATENCY = 2;

  // wait counter and its final value before a hit
  typedef logic [1:0] wait_cnt_t;
  localparam wait_cnt_t LAST_WAIT = wait_cnt_t'(MEM_LATENCY - 1);

  typedef struct packed {
    logic                 imemREN;
    cpu_types_pkg::word_t imemaddr;
    logic                 dmemREN;
    logic                 dmemWEN;
    cpu_types_pkg::word_t dmemaddr;
    cpu_types_pkg::word_t dmemstore;
  } mem_req_t;

  typedef struct packed {
    logic                 ihit;
    cpu_types_pkg::word_t imemload;
    logic                 dhit;
    cpu_types_pkg::word_t dmemload;
  } mem_resp_t;

  typedef struct packed {
    logic                 wen;
    logic [MEM_AW-1:0]    addr;
    cpu_types_pkg::word_t data;
  } ext_port_t;

endpackage

`default_nettype wire

// File: source/cpu_types_pkg.sv
//###########################################################################
// cpu types: instruction formats, opcode and function codes, ALU operations
// and the decoded control word of the single-cycle core
//###########################################################################
`default_nettype none

package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  localparam word_t HALT_WORD = 32'hFFFF_FFFF;

  // major opcodes
  typedef enum logic [5:0] {
    RTYPE = 6'b000000,
    J     = 6'b000010,
    JAL   = 6'b000011,
    BEQ   = 6'b000100,
    BNE   = 6'b000101,
    ADDIU = 6'b001001,
    SLTI  = 6'b001010,
    ANDI  = 6'b001100,
    ORI   = 6'b001101,
    XORI  = 6'b001110,
    LUI   = 6'b001111,
    LW    = 6'b100011,
    SW    = 6'b101011,
    HALT  = 6'b111111
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    JR   = 6'b001000,
    ADDU = 6'b100001,
    SUBU = 6'b100011,
    AND  = 6'b100100,
    OR   = 6'b100101,
    XOR  = 6'b100110,
    NOR  = 6'b100111,
    SLT  = 6'b101010,
    SLTU = 6'b101011
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  typedef struct packed {
    opcode_t    opcode;
    regbits_t   rs;
    regbits_t   rt;
    regbits_t   rd;
    logic [4:0] shamt;
    funct_t     funct;
  } r_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm;
  } i_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr;
  } j_t;

  typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_LUI} imm_sel_t;

  // destination register choice
  typedef enum logic [1:0] {DST_RT, DST_RD, DST_RA} wsel_t;

  typedef struct packed {
    aluop_t   aluop;
    logic     alu_src;
    imm_sel_t imm_sel;
    wsel_t    reg_dst;
    logic     reg_wr;
    logic     mem_to_reg;
    logic     mem_wr;
    logic     mem_rd;
    logic     beq;
    logic     bne;
    logic     jump;
    logic     jal;
    logic     jreg;
    logic     halt;
  } ctrl_t;

endpackage

`default_nettype wire

// File: source/datapath.sv
//###########################################################################
// datapath: pc, immediates, operand and write-back muxes, next pc, halt
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module datapath (
  input  logic                  CLK,
  input  logic                  nRST,
  input  cpu_mem_pkg::mem_resp_t resp,
  output cpu_mem_pkg::mem_req_t  req,
  output logic                  halt
);

  cpu_types_pkg::word_t    pc;
  cpu_types_pkg::word_t    pc_p4;
  cpu_types_pkg::word_t    npc;
  cpu_types_pkg::word_t    br_target;
  cpu_types_pkg::word_t    j_target;
  cpu_types_pkg::word_t    imm_sext;
  cpu_types_pkg::word_t    imm_ext;
  cpu_types_pkg::word_t    alu_a;
  cpu_types_pkg::word_t    alu_b;
  cpu_types_pkg::word_t    alu_out;
  cpu_types_pkg::word_t    rdat1;
  cpu_types_pkg::word_t    rdat2;
  cpu_types_pkg::word_t    wdat;
  cpu_types_pkg::regbits_t wsel;
  cpu_types_pkg::ctrl_t    ctrl;
  cpu_types_pkg::r_t       rtype;
  cpu_types_pkg::i_t       itype;
  cpu_types_pkg::j_t       jtype;
  logic alu_zero;
  logic rf_wen;
  logic pc_en;
  logic dren;
  logic dwen;
  logic br_taken;

  // instruction stays visible on imemload through its data access
  assign rtype = resp.imemload;
  assign itype = resp.imemload;
  assign jtype = resp.imemload;

  control_unit i_ctrl (
    .instr (resp.imemload),
    .ctrl  (ctrl)
  );

  request_unit i_req (
    .CLK     (CLK),
    .nRST    (nRST),
    .ihit    (resp.ihit),
    .dhit    (resp.dhit),
    .mem_rd  (ctrl.mem_rd & ~halt),
    .mem_wr  (ctrl.mem_wr & ~halt),
    .dmemREN (dren),
    .dmemWEN (dwen)
  );

  // loads write back on dhit, everything else on the fetch hit
  assign rf_wen = ctrl.reg_wr & (ctrl.mem_to_reg ? resp.dhit : resp.ihit);

  register_file i_rf (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (rf_wen),
    .wsel  (wsel),
    .rsel1 (rtype.rs),
    .rsel2 (rtype.rt),
    .wdat  (wdat),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  assign imm_sext = {{16{itype.imm[15]}}, itype.imm};

  always_comb begin
    case (ctrl.imm_sel)
      cpu_types_pkg::IMM_ZERO: imm_ext = {16'b0, itype.imm};
      cpu_types_pkg::IMM_LUI:  imm_ext = {itype.imm, 16'b0};
      default:                 imm_ext = imm_sext;
    endcase
  end

  assign alu_a = (ctrl.imm_sel == cpu_types_pkg::IMM_LUI) ? '0 : rdat1;
  assign alu_b = ctrl.alu_src ? imm_ext : rdat2;

  alu i_alu (
    .aluop   (ctrl.aluop),
    .port_a  (alu_a),
    .port_b  (alu_b),
    .outport (alu_out),
    .zero    (alu_zero)
  );

  always_comb begin
    case (ctrl.reg_dst)
      cpu_types_pkg::DST_RD: wsel = rtype.rd;
      cpu_types_pkg::DST_RA: wsel = 5'd31;
      default:               wsel = itype.rt;
    endcase
  end

  assign wdat = ctrl.jal ? pc_p4 : (ctrl.mem_to_reg ? resp.dmemload : alu_out);

  // next pc
  assign pc_p4     = pc + 32'd4;
  assign br_target = pc_p4 + {imm_sext[29:0], 2'b00};
  assign j_target  = {pc_p4[31:28], jtype.addr, 2'b00};
  assign br_taken  = (ctrl.beq & alu_zero) | (ctrl.bne & ~alu_zero);

  always_comb begin
    if (br_taken) begin
      npc = br_target;
    end else if (ctrl.jump || ctrl.jal) begin
      npc = j_target;
    end else if (ctrl.jreg) begin
      npc = rdat1;
    end else begin
      npc = pc_p4;
    end
  end

  assign pc_en = resp.ihit & ~(dren | dwen);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc   <= '0;
      halt <= 1'b0;
    end else if (pc_en) begin
      pc   <= npc;
      halt <= halt | ctrl.halt;
    end
  end

  // fetch stops once halted
  assign req.imemREN   = ~halt;
  assign req.imemaddr  = pc;
  assign req.dmemREN   = dren;
  assign req.dmemWEN   = dwen;
  assign req.dmemaddr  = alu_out;
  assign req.dmemstore = rdat2;

  assert property (@(posedge CLK) disable iff (!nRST) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: source/register_file.sv
//###########################################################################
// register file: 32 x 32 bits, two read ports, r0 reads as zero
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  input  cpu_types_pkg::word_t    wdat,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wen && (wsel != '0)) begin
      regs[wsel] <= wdat;
    end
  end

  // r0 is never written, so it stays at its reset value
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

endmodule

`default_nettype wire

// File: source/request_unit.sv
//###########################################################################
// request unit: one data access per load or store
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module request_unit (
  input  logic CLK,
  input  logic nRST,
  input  logic ihit,
  input  logic dhit,
  input  logic mem_rd,
  input  logic mem_wr,
  output logic dmemREN,
  output logic dmemWEN
);

  logic done;

  // set once the data access hits, cleared when the next fetch lands
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      done <= 1'b0;
    end else if (ihit) begin
      done <= 1'b0;
    end else if (dhit) begin
      done <= 1'b1;
    end
  end

  assign dmemREN = mem_rd & ~done;
  assign dmemWEN = mem_wr & ~done;

  assert property (@(posedge CLK) disable iff (!nRST) !(dmemREN && dmemWEN));

endmodule

`default_nettype wire

// File: source/single_cycle.sv
//###########################################################################
// single-cycle core top: datapath and unified memory
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module single_cycle (
  input  logic                           CLK,
  input  logic                           nRST,
  input  cpu_mem_pkg::ext_port_t         ext,
  input  logic [cpu_mem_pkg::MEM_AW-1:0] dump_addr,
  output cpu_types_pkg::word_t           dump_data,
  output logic                           halt
);

  cpu_mem_pkg::mem_req_t  req;
  cpu_mem_pkg::mem_resp_t resp;

  datapath i_dp (
    .CLK  (CLK),
    .nRST (nRST),
    .resp (resp),
    .req  (req),
    .halt (halt)
  );

  unified_memory i_mem (
    .CLK       (CLK),
    .nRST      (nRST),
    .req       (req),
    .resp      (resp),
    .ext       (ext),
    .dump_addr (dump_addr),
    .dump_data (dump_data)
  );

endmodule

`default_nettype wire

// File: source/unified_memory.sv
//###########################################################################
// unified word memory: data-first arbitration, fixed wait, load and dump
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module unified_memory (
  input  logic                             CLK,
  input  logic                             nRST,
  input  cpu_mem_pkg::mem_req_t            req,
  output cpu_mem_pkg::mem_resp_t           resp,
  input  cpu_mem_pkg::ext_port_t           ext,
  input  logic [cpu_mem_pkg::MEM_AW-1:0]   dump_addr,
  output cpu_types_pkg::word_t             dump_data
);

  typedef enum logic [1:0] {IDLE, DATA, INSTR} state_t;

  state_t                  state;
  cpu_mem_pkg::wait_cnt_t  wait_cnt;
  cpu_types_pkg::word_t    mem [cpu_mem_pkg::MEM_WORDS];
  logic [cpu_mem_pkg::MEM_AW-1:0] iaddr;
  logic [cpu_mem_pkg::MEM_AW-1:0] daddr;
  logic dreq;
  logic last;
  logic ihit;
  logic dhit;

  assign iaddr = req.imemaddr[cpu_mem_pkg::MEM_AW+1:2];
  assign daddr = req.dmemaddr[cpu_mem_pkg::MEM_AW+1:2];
  assign dreq  = req.dmemREN | req.dmemWEN;
  assign last  = (wait_cnt == cpu_mem_pkg::LAST_WAIT);

  // the idle cycle that sees the request counts as the first wait cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      wait_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (dreq) begin
            state    <= DATA;
            wait_cnt <= cpu_mem_pkg::wait_cnt_t'(1);
          end else if (req.imemREN) begin
            state    <= INSTR;
            wait_cnt <= cpu_mem_pkg::wait_cnt_t'(1);
          end
        end
        DATA, INSTR: begin
          if (last) begin
            state    <= IDLE;
            wait_cnt <= '0;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign dhit = (state == DATA) && last && dreq;
  assign ihit = (state == INSTR) && last && req.imemREN;

  // load port wins over a store in the same cycle
  always_ff @(posedge CLK) begin
    if (ext.wen) begin
      mem[ext.addr] <= ext.data;
    end else if (dhit && req.dmemWEN) begin
      mem[daddr] <= req.dmemstore;
    end
  end

  assign resp.ihit     = ihit;
  assign resp.dhit     = dhit;
  assign resp.imemload = mem[iaddr];
  assign resp.dmemload = dhit ? mem[daddr] : '0;
  assign dump_data     = mem[dump_addr];

  // a granted request is held as a level until its hit
  assert property (@(posedge CLK) disable iff (!nRST) (state == DATA) |-> dreq);
  assert property (@(posedge CLK) disable iff (!nRST) (state == INSTR) |-> req.imemREN);

endmodule

`default_nettype wire

// File: verification/tb_isa_model.svh
//###########################################################################
// ISA helpers for the core testbench: encoders, LFSR, program builders
// and the reference model that produces the expected memory image
//###########################################################################
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

function automatic cpu_types_pkg::word_t rtype_word(cpu_types_pkg::funct_t fn,
    cpu_types_pkg::regbits_t rd, cpu_types_pkg::regbits_t rs,
    cpu_types_pkg::regbits_t rt);
  return {cpu_types_pkg::RTYPE, rs, rt, rd, 5'b0, fn};
endfunction

// argument order follows the assembly form: op rt, rs, imm
function automatic cpu_types_pkg::word_t itype_word(cpu_types_pkg::opcode_t op,
    cpu_types_pkg::regbits_t rt, cpu_types_pkg::regbits_t rs, logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic cpu_types_pkg::word_t jump_word(cpu_types_pkg::opcode_t op, int idx);
  return {op, 26'(idx)};
endfunction

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic lfsr_next();
  logic fb;
  fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
  lfsr = {lfsr[14:0], fb};
  return fb;
endfunction

function automatic logic [31:0] random_bits(int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_next()};
  end
  return v;
endfunction

// work registers r1 to r8
function automatic cpu_types_pkg::regbits_t rand_reg();
  return 5'(random_bits(3)) + 5'd1;
endfunction

function automatic cpu_types_pkg::funct_t random_funct();
  case (random_bits(3))
    32'd0: return cpu_types_pkg::ADDU;
    32'd1: return cpu_types_pkg::SUBU;
    32'd2: return cpu_types_pkg::AND;
    32'd3: return cpu_types_pkg::OR;
    32'd4: return cpu_types_pkg::XOR;
    32'd5: return cpu_types_pkg::NOR;
    32'd6: return cpu_types_pkg::SLT;
    default: return cpu_types_pkg::SLTU;
  endcase
endfunction

function automatic cpu_types_pkg::opcode_t random_iop();
  case (random_bits(3))
    32'd1: return cpu_types_pkg::SLTI;
    32'd2: return cpu_types_pkg::ANDI;
    32'd3: return cpu_types_pkg::ORI;
    32'd4: return cpu_types_pkg::XORI;
    32'd5: return cpu_types_pkg::LUI;
    32'd6: return cpu_types_pkg::SLTI;
    default: return cpu_types_pkg::ADDIU;
  endcase
endfunction

function automatic void emit(cpu_types_pkg::word_t w);
  prog.push_back(w);
endfunction

function automatic cpu_types_pkg::word_t fill_word(logic [7:0] a);
  return {a, ~a, a ^ 8'h5A, a ^ 8'hC3};
endfunction

function automatic void load_random_regs();
  for (int r = 1; r <= 8; r++) begin
    emit(itype_word(cpu_types_pkg::LUI, 5'(r), 5'd0, 16'(random_bits(16))));
    emit(itype_word(cpu_types_pkg::ORI, 5'(r), 5'(r), 16'(random_bits(16))));
  end
endfunction

// register n lands at word 224 + n, then the core stops
function automatic void store_all_regs();
  for (int n = 0; n < 32; n++) begin
    emit(itype_word(cpu_types_pkg::SW, 5'(n), 5'd0, 16'(16'h0380 + 4 * n)));
  end
  emit(cpu_types_pkg::HALT_WORD);
endfunction

function automatic void alu_program();
  load_random_regs();
  repeat (24) begin
    emit(rtype_word(random_funct(), rand_reg(), rand_reg(), rand_reg()));
  end
  // negative against small positive splits SLT from SLTU
  emit(itype_word(cpu_types_pkg::LUI, 5'd9, 5'd0, 16'h8000));
  emit(itype_word(cpu_types_pkg::ORI, 5'd10, 5'd0, 16'h0005));
  emit(rtype_word(cpu_types_pkg::SLT, 5'd11, 5'd9, 5'd10));
  emit(rtype_word(cpu_types_pkg::SLTU, 5'd12, 5'd9, 5'd10));
  store_all_regs();
endfunction

function automatic void imm_program();
  load_random_regs();
  emit(itype_word(cpu_types_pkg::ADDIU, 5'd9, 5'd0, 16'hFFFF));
  emit(itype_word(cpu_types_pkg::ORI, 5'd10, 5'd0, 16'hFFFF));
  emit(itype_word(cpu_types_pkg::SLTI, 5'd11, 5'd9, 16'h0000));
  emit(itype_word(cpu_types_pkg::LUI, 5'd12, 5'd0, 16'hABCD));
  emit(itype_word(cpu_types_pkg::XORI, 5'd13, 5'd9, 16'h8000));
  emit(itype_word(cpu_types_pkg::ANDI, 5'd14, 5'd9, 16'h8001));
  repeat (20) begin
    emit(itype_word(random_iop(), rand_reg(), rand_reg(), 16'(random_bits(16))));
  end
  store_all_regs();
endfunction

function automatic void mem_program();
  logic [15:0] off;
  cpu_types_pkg::regbits_t rv;
  load_random_regs();
  // r20 points at the data area, word 128
  emit(itype_word(cpu_types_pkg::ORI, 5'd20, 5'd0, 16'h0200));
  repeat (12) begin
    off = 16'(random_bits(6)) << 2;
    emit(itype_word(cpu_types_pkg::SW, rand_reg(), 5'd20, off));
    rv = rand_reg();
    emit(itype_word(cpu_types_pkg::LW, rv, 5'd20, off));
    emit(rtype_word(cpu_types_pkg::ADDU, rand_reg(), rv, 5'd1));
    off = 16'(random_bits(6)) << 2;
    emit(itype_word(cpu_types_pkg::LW, rand_reg(), 5'd20, off));
  end
  store_all_regs();
endfunction

// word indices are fixed, jump fields and branch offsets depend on them
function automatic void branch_program();
  emit(itype_word(cpu_types_pkg::ORI, 5'd1, 5'd0, 16'd5));
  emit(itype_word(cpu_types_pkg::ORI, 5'd2, 5'd0, 16'd0));
  // loop body at word 2
  emit(rtype_word(cpu_types_pkg::ADDU, 5'd2, 5'd2, 5'd1));
  emit(itype_word(cpu_types_pkg::ADDIU, 5'd1, 5'd1, 16'hFFFF));
  emit(itype_word(cpu_types_pkg::BNE, 5'd0, 5'd1, 16'hFFFD));
  // r1 is 0 and r2 is 15 here, so no branch
  emit(itype_word(cpu_types_pkg::BEQ, 5'd2, 5'd1, 16'd3));
  emit(itype_word(cpu_types_pkg::ORI, 5'd3, 5'd0, 16'h0011));
  emit(jump_word(cpu_types_pkg::J, 9));
  emit(itype_word(cpu_types_pkg::ORI, 5'd4, 5'd0, 16'h0BAD));
  emit(jump_word(cpu_types_pkg::JAL, 12));
  emit(itype_word(cpu_types_pkg::ORI, 5'd5, 5'd0, 16'h0022));
  emit(jump_word(cpu_types_pkg::J, 14));
  // subroutine at word 12
  emit(itype_word(cpu_types_pkg::ADDIU, 5'd6, 5'd2, 16'd100));
  emit(rtype_word(cpu_types_pkg::JR, 5'd0, 5'd31, 5'd0));
  store_all_regs();
endfunction

function automatic void zero_reg_program();
  load_random_regs();
  emit(itype_word(cpu_types_pkg::ADDIU, 5'd0, 5'd0, 16'h1234));
  emit(itype_word(cpu_types_pkg::ORI, 5'd0, 5'd3, 16'h00FF));
  emit(rtype_word(cpu_types_pkg::ADDU, 5'd0, 5'd1, 5'd2));
  emit(itype_word(cpu_types_pkg::LUI, 5'd0, 5'd0, 16'h8000));
  emit(itype_word(cpu_types_pkg::SW, 5'd4, 5'd0, 16'h0200));
  emit(itype_word(cpu_types_pkg::LW, 5'd0, 5'd0, 16'h0200));
  emit(rtype_word(cpu_types_pkg::ADDU, 5'd7, 5'd0, 5'd4));
  store_all_regs();
endfunction

function automatic void program_image(int which);
  prog.delete();
  for (int a = 0; a < cpu_mem_pkg::MEM_WORDS; a++) begin
    prog_mem[a] = fill_word(8'(a));
  end
  case (which)
    0: alu_program();
    1: imm_program();
    2: mem_program();
    3: branch_program();
    default: zero_reg_program();
  endcase
  foreach (prog[i]) begin
    prog_mem[i] = prog[i];
  end
endfunction

// runs the image in prog_mem, leaves the final memory in exp_mem and
// returns the number of instructions executed, halt included
function automatic int isa_run();
  cpu_types_pkg::word_t regs [32];
  cpu_types_pkg::word_t pc;
  cpu_types_pkg::word_t npc;
  cpu_types_pkg::word_t ins;
  cpu_types_pkg::word_t a;
  cpu_types_pkg::word_t b;
  cpu_types_pkg::word_t sx;
  cpu_types_pkg::word_t zx;
  cpu_types_pkg::word_t ea;
  cpu_types_pkg::word_t res;
  logic [4:0] wr;
  logic we;
  logic stop;
  int steps;
  foreach (regs[r]) begin
    regs[r] = '0;
  end
  foreach (exp_mem[m]) begin
    exp_mem[m] = prog_mem[m];
  end
  pc = '0;
  steps = 0;
  stop = 1'b0;
  while (!stop && steps < 4000) begin
    ins = exp_mem[pc[9:2]];
    a = regs[ins[25:21]];
    b = regs[ins[20:16]];
    sx = {{16{ins[15]}}, ins[15:0]};
    zx = {16'b0, ins[15:0]};
    ea = a + sx;
    npc = pc + 32'd4;
    wr = ins[20:16];
    we = 1'b1;
    res = '0;
    steps++;
    case (ins[31:26])
      cpu_types_pkg::RTYPE: begin
        wr = ins[15:11];
        case (ins[5:0])
          cpu_types_pkg::ADDU: res = a + b;
          cpu_types_pkg::SUBU: res = a - b;
          cpu_types_pkg::AND:  res = a & b;
          cpu_types_pkg::OR:   res = a | b;
          cpu_types_pkg::XOR:  res = a ^ b;
          cpu_types_pkg::NOR:  res = ~(a | b);
          cpu_types_pkg::SLT:  res = {31'b0, $signed(a) < $signed(b)};
          cpu_types_pkg::SLTU: res = {31'b0, a < b};
          cpu_types_pkg::JR: begin
            we = 1'b0;
            npc = a;
          end
          default: we = 1'b0;
        endcase
      end
      cpu_types_pkg::J: begin
        we = 1'b0;
        npc = {npc[31:28], ins[25:0], 2'b00};
      end
      cpu_types_pkg::JAL: begin
        wr = 5'd31;
        res = npc;
        npc = {npc[31:28], ins[25:0], 2'b00};
      end
      cpu_types_pkg::BEQ: begin
        we = 1'b0;
        if (a == b) npc = npc + {sx[29:0], 2'b00};
      end
      cpu_types_pkg::BNE: begin
        we = 1'b0;
        if (a != b) npc = npc + {sx[29:0], 2'b00};
      end
      cpu_types_pkg::ADDIU: res = ea;
      cpu_types_pkg::SLTI:  res = {31'b0, $signed(a) < $signed(sx)};
      cpu_types_pkg::ANDI:  res = a & zx;
      cpu_types_pkg::ORI:   res = a | zx;
      cpu_types_pkg::XORI:  res = a ^ zx;
      cpu_types_pkg::LUI:   res = {ins[15:0], 16'b0};
      cpu_types_pkg::LW:    res = exp_mem[ea[9:2]];
      cpu_types_pkg::SW: begin
        we = 1'b0;
        exp_mem[ea[9:2]] = b;
      end
      cpu_types_pkg::HALT: begin
        we = 1'b0;
        stop = 1'b1;
      end
      default: we = 1'b0;
    endcase
    if (we && wr != 5'd0) regs[wr] = res;
    pc = npc;
  end
  return steps;
endfunction

`endif

// File: verification/single_cycle_tb.sv
//###########################################################################
// testbench for the single-cycle core: loads programs, runs to halt and
// compares the final memory with the reference model
//###########################################################################
`timescale 1ns/1ps
`default_nettype none

module single_cycle_tb;

  logic                            CLK = 1'b0;
  logic                            nRST;
  cpu_mem_pkg::ext_port_t          ext;
  logic [cpu_mem_pkg::MEM_AW-1:0]  dump_addr;
  cpu_types_pkg::word_t            dump_data;
  logic                            halt;

  cpu_types_pkg::word_t prog_mem [cpu_mem_pkg::MEM_WORDS];
  cpu_types_pkg::word_t exp_mem [cpu_mem_pkg::MEM_WORDS];
  cpu_types_pkg::word_t prog [$];
  logic [15:0] lfsr;
  logic        running;
  int          cycle_cnt;
  int          cycle_limit;
  int          prog_id;
  event        check_go;
  event        check_done;

  `include "tb_isa_model.svh"

  single_cycle i_dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .ext       (ext),
    .dump_addr (dump_addr),
    .dump_data (dump_data),
    .halt      (halt)
  );

  always #2 CLK = ~CLK;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  // core held in reset while the whole array is written
  task automatic load_and_reset();
    @(negedge CLK);
    nRST = 1'b0;
    for (int i = 0; i < cpu_mem_pkg::MEM_WORDS; i++) begin
      ext.wen  = 1'b1;
      ext.addr = 8'(i);
      ext.data = prog_mem[i];
      @(negedge CLK);
    end
    ext = '0;
    repeat (3) @(negedge CLK);
    nRST = 1'b1;
  endtask

  // watchdog on the run to halt
  always @(posedge CLK) begin
    if (!running) begin
      cycle_cnt <= 0;
    end else if (cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("timeout: halt did not rise within %0d cycles on program %0d",
                          cycle_limit, prog_id));
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  // dump compare, address driven on the falling edge
  initial begin
    cpu_types_pkg::word_t got;
    dump_addr = '0;
    forever begin
      @(check_go);
      for (int a = 0; a < cpu_mem_pkg::MEM_WORDS; a++) begin
        @(negedge CLK);
        dump_addr = 8'(a);
        @(posedge CLK);
        got = dump_data;
        assert (got === exp_mem[a]) else begin
          abort_run($sformatf("FAILED at %0t ns: program %0d word %0d expected %08h got %08h",
                              $time, prog_id, a, exp_mem[a], got));
        end
      end
      -> check_done;
    end
  end

  initial begin
    int steps;
    nRST        = 1'b0;
    ext         = '0;
    running     = 1'b0;
    cycle_limit = 0;
    prog_id     = 0;
    lfsr        = 16'd55562;
    for (int p = 0; p < 5; p++) begin
      prog_id = p;
      program_image(p);
      steps = isa_run();
      cycle_limit = steps * 2 * cpu_mem_pkg::MEM_LATENCY + 50;
      load_and_reset();
      running = 1'b1;
      while (halt !== 1'b1) @(negedge CLK);
      running = 1'b0;
      -> check_go;
      @(check_done);
      // halted core must stay put
      repeat (20) begin
        @(negedge CLK);
        assert (halt === 1'b1) else begin
          abort_run($sformatf("FAILED at %0t ns: program %0d halt fell after rising",
                              $time, prog_id));
        end
      end
      -> check_go;
      @(check_done);
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire
